// ==== verilog.f ====
+incdir+.
periph_pkg.sv
axil_to_reg.sv
periph_decode.sv
plic_lite.sv
gpio_regs.sv
ariane_peripherals.sv
tb_ariane_peripherals.sv

// ==== Makefile ====
# Verilator build and run of the peripheral subsystem testbench

TOP := tb_ariane_peripherals

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
		--top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== tb_ariane_peripherals.sv ====
/*
 * Testbench for the peripheral subsystem
 * AXI4-Lite accesses from a table, LED, DIP switch and interrupt tests
 */
`timescale 1ns/1ps
`include "periph_settings.svh"

module tb_ariane_peripherals;

    localparam int AW      = `PERIPH_ADDR_W;
    localparam int DW      = `PERIPH_DATA_W;
    localparam int GW      = `PERIPH_GPIO_W;
    localparam int TIMEOUT = 40;   // Cycles per wait

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Register map
    localparam logic [AW-1:0] PLIC_PEND   = `PLIC_BASE + 32'h080;
    localparam logic [AW-1:0] PLIC_EN0    = `PLIC_BASE + 32'h100;
    localparam logic [AW-1:0] PLIC_EN1    = `PLIC_BASE + 32'h104;
    localparam logic [AW-1:0] PLIC_THR0   = `PLIC_BASE + 32'h200;
    localparam logic [AW-1:0] PLIC_CLAIM0 = `PLIC_BASE + 32'h204;
    localparam logic [AW-1:0] PLIC_THR1   = `PLIC_BASE + 32'h210;
    localparam logic [AW-1:0] PLIC_CLAIM1 = `PLIC_BASE + 32'h214;
    localparam logic [AW-1:0] GPIO_LED    = `GPIO_BASE + 32'h0;
    localparam logic [AW-1:0] GPIO_DIP    = `GPIO_BASE + 32'h4;
    localparam logic [AW-1:0] GPIO_STAT   = `GPIO_BASE + 32'h8;
    localparam logic [AW-1:0] GPIO_IE     = `GPIO_BASE + 32'hC;

    typedef struct packed {
        logic          write;
        logic [AW-1:0] addr;
        logic [DW-1:0] wdata;
        logic [DW-1:0] exp_rdata;   // Ignored for writes
        logic [1:0]    exp_resp;
    } access_t;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        awvalid, awready, wvalid, wready, bvalid, bready;
    logic                        arvalid, arready, rvalid, rready;
    logic [AW-1:0]               awaddr, araddr;
    logic [DW-1:0]               wdata, rdata;
    logic [DW/8-1:0]             wstrb;
    periph_pkg::axi_resp_e       bresp, rresp;
    logic [`PERIPH_NUM_SRC-2:0]  ext_irq;
    logic [`PERIPH_NUM_TGT-1:0]  irq;
    logic [GW-1:0]               leds, dip;

    access_t       table_q[$];
    logic [GW-1:0] led_model;
    int            n_tests = 0;
    int            n_checks = 0;
    int            n_errors = 0;
    int            test_start_errors = 0;

    ariane_peripherals ariane_peripherals_i (
        .clk_i ( clk ), .rst_n_i ( rst_n ),
        .awvalid_i ( awvalid ), .awready_o ( awready ), .awaddr_i ( awaddr ),
        .wvalid_i ( wvalid ), .wready_o ( wready ), .wdata_i ( wdata ), .wstrb_i ( wstrb ),
        .bvalid_o ( bvalid ), .bready_i ( bready ), .bresp_o ( bresp ),
        .arvalid_i ( arvalid ), .arready_o ( arready ), .araddr_i ( araddr ),
        .rvalid_o ( rvalid ), .rready_i ( rready ), .rdata_o ( rdata ), .rresp_o ( rresp ),
        .ext_irq_i ( ext_irq ), .irq_o ( irq ), .leds_o ( leds ), .dip_switches_i ( dip )
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    endtask

    // ------------------------------
    // AXI4-Lite master
    // ------------------------------
    task automatic axil_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                              input logic [DW/8-1:0] strb, output logic [1:0] resp);
        int cycles;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        cycles = 0;
        @(negedge clk);
        while (!(awready && wready) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!(awready && wready)) report_timeout("awready and wready");
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!bvalid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!bvalid) report_timeout("bvalid");
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [AW-1:0] addr, output logic [DW-1:0] data,
                             output logic [1:0] resp);
        int cycles;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        cycles = 0;
        @(negedge clk);
        while (!arready && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!arready) report_timeout("arready");
        @(posedge clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!rvalid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rvalid) report_timeout("rvalid");
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------
    task automatic add_access(input logic write, input logic [AW-1:0] addr,
                              input logic [DW-1:0] data, input logic [DW-1:0] exp_rdata,
                              input logic [1:0] exp_resp);
        table_q.push_back(access_t'{write, addr, data, exp_rdata, exp_resp});
    endtask

    task automatic apply_table();
        access_t       a;
        logic [DW-1:0] data;
        logic [1:0]    resp;
        foreach (table_q[i]) begin
            a = table_q[i];
            if (a.write) begin
                axil_write(a.addr, a.wdata, '1, resp);
                check_value($sformatf("bresp @%h", a.addr), 32'(resp), 32'(a.exp_resp));
            end else begin
                axil_read(a.addr, data, resp);
                check_value($sformatf("rdata @%h", a.addr), data, a.exp_rdata);
                check_value($sformatf("rresp @%h", a.addr), 32'(resp), 32'(a.exp_resp));
            end
        end
        table_q.delete();
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (n_errors == test_start_errors) begin
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            $display("test %0d %s: %0d errors", n_tests, name, n_errors - test_start_errors);
        end
        test_start_errors = n_errors;
    endtask

    task automatic check_irq(input logic [`PERIPH_NUM_TGT-1:0] expected);
        @(negedge clk);
        check_value("irq_o", 32'(irq), 32'(expected));
    endtask

    initial begin
        logic [DW-1:0]   data;
        logic [DW-1:0]   wval;
        logic [DW/8-1:0] strb;
        logic [1:0]      resp;
        logic [GW-1:0]   dip_old;
        logic [GW-1:0]   dip_new;
        int              cycles;

        void'($urandom(32'h8514_9c65));
        rst_n     = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ext_irq   = '0;
        dip       = 8'h5A;
        led_model = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        check_irq('0);
        check_value("leds_o", 32'(leds), 32'h0);
        add_access(1'b0, PLIC_PEND, '0, 32'h0, RESP_OKAY);
        add_access(1'b0, GPIO_STAT, '0, 32'h0, RESP_OKAY);
        add_access(1'b0, GPIO_LED, '0, 32'h0, RESP_OKAY);
        apply_table();
        end_test("reset state");

        // Odd LED writes leave byte 0 unstrobed
        for (int i = 0; i < 8; i++) begin
            wval = $urandom;
            strb = (i % 2 == 0) ? 4'hF : {3'($urandom), 1'b0};
            axil_write(GPIO_LED, wval, strb, resp);
            check_value("bresp", 32'(resp), 32'(RESP_OKAY));
            for (int b = 0; b < GW / 8; b++) begin
                if (strb[b]) led_model[b*8 +: 8] = wval[b*8 +: 8];
            end
            axil_read(GPIO_LED, data, resp);
            check_value("rdata led", data, 32'(led_model));
            check_value("rresp", 32'(resp), 32'(RESP_OKAY));
            @(negedge clk);
            check_value("leds_o", 32'(leds), 32'(led_model));
        end
        end_test("LED writes");

        // DIP switches
        dip_old = dip;
        dip_new = 8'hA3;
        @(posedge clk);
        dip <= dip_new;
        cycles = 0;
        data = '0;
        while (data[GW-1:0] !== dip_new && cycles < TIMEOUT) begin
            axil_read(GPIO_DIP, data, resp);
            cycles++;
        end
        if (data[GW-1:0] !== dip_new) report_timeout("the DIP register to show new switches");
        add_access(1'b0, GPIO_STAT, '0, 32'(dip_old ^ dip_new), RESP_OKAY);
        add_access(1'b1, GPIO_STAT, 32'h0F, '0, RESP_OKAY);
        add_access(1'b0, GPIO_STAT, '0, 32'((dip_old ^ dip_new) & 8'hF0), RESP_OKAY);
        add_access(1'b1, GPIO_STAT, 32'hFF, '0, RESP_OKAY);
        add_access(1'b0, GPIO_STAT, '0, 32'h0, RESP_OKAY);
        apply_table();
        end_test("DIP switches");

        // Unmapped addresses
        add_access(1'b1, 32'h0000_2000, 32'h1234_5678, '0, RESP_SLVERR);
        add_access(1'b0, 32'h0000_2000, '0, 32'hDEAD_BEEF, RESP_SLVERR);
        add_access(1'b0, 32'h0000_1100, '0, 32'hDEAD_BEEF, RESP_SLVERR);
        add_access(1'b1, 32'h8000_0000, 32'hFFFF_FFFF, '0, RESP_SLVERR);
        add_access(1'b0, 32'hFFFF_FFFC, '0, 32'hDEAD_BEEF, RESP_SLVERR);
        add_access(1'b0, GPIO_LED, '0, 32'(led_model), RESP_OKAY);
        apply_table();
        end_test("unmapped addresses");

        // ------------------------------
        // PLIC priority and claim
        // ------------------------------
        add_access(1'b1, PLIC_THR0, 32'd7, '0, RESP_OKAY);
        add_access(1'b1, `PLIC_BASE + 32'h8, 32'd3, '0, RESP_OKAY);    // Source 2
        add_access(1'b1, `PLIC_BASE + 32'hC, 32'd5, '0, RESP_OKAY);    // Source 3
        add_access(1'b1, `PLIC_BASE + 32'h10, 32'd5, '0, RESP_OKAY);   // Source 4
        add_access(1'b1, PLIC_EN0, 32'h1C, '0, RESP_OKAY);
        add_access(1'b0, `PLIC_BASE + 32'h8, '0, 32'd3, RESP_OKAY);
        add_access(1'b0, PLIC_EN0, '0, 32'h1C, RESP_OKAY);
        apply_table();
        @(posedge clk);
        ext_irq <= 3'b111;
        add_access(1'b0, PLIC_PEND, '0, 32'h1C, RESP_OKAY);
        apply_table();
        check_irq(2'b00);   // Threshold above every priority
        axil_write(PLIC_THR0, 32'd4, '1, resp);
        check_irq(2'b01);
        add_access(1'b1, PLIC_THR0, 32'd2, '0, RESP_OKAY);
        add_access(1'b0, PLIC_CLAIM0, '0, 32'd3, RESP_OKAY);
        add_access(1'b0, PLIC_CLAIM0, '0, 32'd4, RESP_OKAY);
        add_access(1'b0, PLIC_CLAIM0, '0, 32'd2, RESP_OKAY);
        add_access(1'b0, PLIC_CLAIM0, '0, 32'd0, RESP_OKAY);
        add_access(1'b0, PLIC_PEND, '0, 32'h0, RESP_OKAY);
        add_access(1'b1, PLIC_CLAIM0, 32'd3, '0, RESP_OKAY);   // Level still high
        add_access(1'b0, PLIC_PEND, '0, 32'h08, RESP_OKAY);
        apply_table();
        check_irq(2'b01);
        @(posedge clk);
        ext_irq <= '0;
        add_access(1'b0, PLIC_CLAIM0, '0, 32'd3, RESP_OKAY);
        add_access(1'b1, PLIC_CLAIM0, 32'd3, '0, RESP_OKAY);
        add_access(1'b1, PLIC_CLAIM0, 32'd4, '0, RESP_OKAY);
        add_access(1'b1, PLIC_CLAIM0, 32'd2, '0, RESP_OKAY);
        add_access(1'b0, PLIC_PEND, '0, 32'h0, RESP_OKAY);
        add_access(1'b0, PLIC_CLAIM0, '0, 32'd0, RESP_OKAY);
        apply_table();
        check_irq(2'b00);
        end_test("PLIC priority and claim");

        // GPIO interrupt through the PLIC
        add_access(1'b1, `PLIC_BASE + 32'h4, 32'd1, '0, RESP_OKAY);    // Source 1
        add_access(1'b1, PLIC_EN1, 32'h02, '0, RESP_OKAY);
        add_access(1'b1, PLIC_THR1, 32'd0, '0, RESP_OKAY);
        add_access(1'b1, GPIO_IE, 32'hFF, '0, RESP_OKAY);
        apply_table();
        check_irq(2'b00);
        @(posedge clk);
        dip <= dip ^ 8'h01;
        cycles = 0;
        @(negedge clk);
        while (!irq[1] && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!irq[1]) report_timeout("irq_o[1] after a switch change");
        add_access(1'b0, PLIC_CLAIM1, '0, 32'd1, RESP_OKAY);
        add_access(1'b1, GPIO_STAT, 32'hFF, '0, RESP_OKAY);
        add_access(1'b1, PLIC_CLAIM1, 32'd1, '0, RESP_OKAY);
        add_access(1'b0, PLIC_PEND, '0, 32'h0, RESP_OKAY);
        apply_table();
        check_irq(2'b00);
        end_test("GPIO interrupt");

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== ariane_peripherals.sv ====
/*
 * Peripheral subsystem top
 * AXI4-Lite bridge, address decoder, PLIC and GPIO
 */
`timescale 1ns/1ps
`include "periph_settings.svh"

module ariane_peripherals (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  logic [`PERIPH_ADDR_W-1:0]     awaddr_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    input  logic [`PERIPH_DATA_W-1:0]     wdata_i,
    input  logic [`PERIPH_DATA_W/8-1:0]   wstrb_i,
    output logic                          bvalid_o,
    input  logic                          bready_i,
    output periph_pkg::axi_resp_e         bresp_o,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    input  logic [`PERIPH_ADDR_W-1:0]     araddr_i,
    output logic                          rvalid_o,
    input  logic                          rready_i,
    output logic [`PERIPH_DATA_W-1:0]     rdata_o,
    output periph_pkg::axi_resp_e         rresp_o,
    input  logic [`PERIPH_NUM_SRC-2:0]    ext_irq_i,
    output logic [`PERIPH_NUM_TGT-1:0]    irq_o,
    output logic [`PERIPH_GPIO_W-1:0]     leds_o,
    input  logic [`PERIPH_GPIO_W-1:0]     dip_switches_i
);

    logic                        req_valid, req_write;
    logic [`PERIPH_ADDR_W-1:0]   req_addr, slv_offset;
    logic [`PERIPH_DATA_W-1:0]   req_wdata, slv_wdata;
    logic [`PERIPH_DATA_W/8-1:0] req_wstrb, slv_wstrb;
    logic                        rsp_valid, rsp_err, slv_write;
    logic [`PERIPH_DATA_W-1:0]   rsp_rdata, plic_rdata, gpio_rdata;
    logic                        plic_req, plic_rsp_valid;
    logic                        gpio_req, gpio_rsp_valid, gpio_irq;
    logic [`PERIPH_NUM_SRC-1:0]  irq_sources;

    assign irq_sources = {ext_irq_i, gpio_irq};   // GPIO is source 1

    // ------------------------------
    // Bridge and decoder
    // ------------------------------
    axil_to_reg i_axil_to_reg (
        .clk_i, .rst_n_i,
        .awvalid_i, .awready_o, .awaddr_i, .wvalid_i, .wready_o, .wdata_i, .wstrb_i,
        .bvalid_o, .bready_i, .bresp_o,
        .arvalid_i, .arready_o, .araddr_i, .rvalid_o, .rready_i, .rdata_o, .rresp_o,
        .req_valid_o ( req_valid ), .req_write_o ( req_write ), .req_addr_o ( req_addr ),
        .req_wdata_o ( req_wdata ), .req_wstrb_o ( req_wstrb ),
        .rsp_valid_i ( rsp_valid ), .rsp_rdata_i ( rsp_rdata ), .rsp_err_i ( rsp_err )
    );

    periph_decode i_periph_decode (
        .clk_i, .rst_n_i,
        .req_valid_i ( req_valid ), .req_write_i ( req_write ), .req_addr_i ( req_addr ),
        .req_wdata_i ( req_wdata ), .req_wstrb_i ( req_wstrb ),
        .plic_req_o ( plic_req ), .gpio_req_o ( gpio_req ), .slv_write_o ( slv_write ),
        .slv_offset_o ( slv_offset ), .slv_wdata_o ( slv_wdata ), .slv_wstrb_o ( slv_wstrb ),
        .plic_rsp_valid_i ( plic_rsp_valid ), .plic_rdata_i ( plic_rdata ),
        .gpio_rsp_valid_i ( gpio_rsp_valid ), .gpio_rdata_i ( gpio_rdata ),
        .rsp_valid_o ( rsp_valid ), .rsp_rdata_o ( rsp_rdata ), .rsp_err_o ( rsp_err )
    );

    // ------------------------------
    // Slaves
    // ------------------------------
    plic_lite i_plic (
        .clk_i, .rst_n_i,
        .req_i ( plic_req ), .write_i ( slv_write ), .offset_i ( slv_offset ),
        .wdata_i ( slv_wdata ), .irq_src_i ( irq_sources ),
        .rsp_valid_o ( plic_rsp_valid ), .rdata_o ( plic_rdata ), .irq_o
    );

    gpio_regs i_gpio (
        .clk_i, .rst_n_i,
        .req_i ( gpio_req ), .write_i ( slv_write ), .offset_i ( slv_offset ),
        .wdata_i ( slv_wdata ), .wstrb_i ( slv_wstrb ), .dip_i ( dip_switches_i ),
        .rsp_valid_o ( gpio_rsp_valid ), .rdata_o ( gpio_rdata ), .leds_o,
        .irq_o ( gpio_irq )
    );

endmodule

// ==== gpio_regs.sv ====
/*
 * GPIO registers
 * LEDs, synchronized DIP switches and a change interrupt
 */
`timescale 1ns/1ps
`include "periph_settings.svh"

module gpio_regs (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_i,
    input  logic                          write_i,
    input  logic [`PERIPH_ADDR_W-1:0]     offset_i,
    input  logic [`PERIPH_DATA_W-1:0]     wdata_i,
    input  logic [`PERIPH_DATA_W/8-1:0]   wstrb_i,
    input  logic [`PERIPH_GPIO_W-1:0]     dip_i,
    output logic                          rsp_valid_o,
    output logic [`PERIPH_DATA_W-1:0]     rdata_o,
    output logic [`PERIPH_GPIO_W-1:0]     leds_o,
    output logic                          irq_o
);

    localparam int GW = `PERIPH_GPIO_W;
    localparam int DW = `PERIPH_DATA_W;

    logic [GW-1:0] dip_meta_q;
    logic [GW-1:0] dip_sync_q;
    logic [GW-1:0] dip_prev_q;
    logic [GW-1:0] status_q;
    logic [GW-1:0] ie_q;
    logic [DW-1:0] rdata_d;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Start in step with the switches so reset flags no change
            dip_meta_q  <= dip_i;
            dip_sync_q  <= dip_i;
            dip_prev_q  <= dip_i;
            leds_o      <= '0;
            status_q    <= '0;
            ie_q        <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            dip_meta_q  <= dip_i;
            dip_sync_q  <= dip_meta_q;
            dip_prev_q  <= dip_sync_q;
            rsp_valid_o <= req_i;
            status_q    <= status_q | (dip_sync_q ^ dip_prev_q);   // set beats clear
            if (req_i && write_i) begin
                case (offset_i[7:0])
                    8'h00: begin
                        for (int b = 0; b < GW / 8; b++) begin
                            if (wstrb_i[b]) leds_o[b*8 +: 8] <= wdata_i[b*8 +: 8];
                        end
                    end
                    8'h08: status_q <= (status_q & ~wdata_i[GW-1:0]) | (dip_sync_q ^ dip_prev_q);
                    8'h0C: ie_q <= wdata_i[GW-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (offset_i[7:0])
            8'h00:   rdata_d = DW'(leds_o);
            8'h04:   rdata_d = DW'(dip_sync_q);
            8'h08:   rdata_d = DW'(status_q);
            8'h0C:   rdata_d = DW'(ie_q);
            default: rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (req_i && !write_i) rdata_o <= rdata_d;
    end

    assign irq_o = |(status_q & ie_q);

endmodule

// ==== plic_lite.sv ====
/*
 * Small PLIC with level gateways
 * Per-source priority, per-target enable, threshold and claim/complete
 */
`timescale 1ns/1ps
`include "periph_settings.svh"

module plic_lite (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_i,
    input  logic                          write_i,
    input  logic [`PERIPH_ADDR_W-1:0]     offset_i,
    input  logic [`PERIPH_DATA_W-1:0]     wdata_i,
    input  logic [`PERIPH_NUM_SRC-1:0]    irq_src_i,
    output logic                          rsp_valid_o,
    output logic [`PERIPH_DATA_W-1:0]     rdata_o,
    output logic [`PERIPH_NUM_TGT-1:0]    irq_o
);

    localparam int NS = `PERIPH_NUM_SRC;
    localparam int NT = `PERIPH_NUM_TGT;
    localparam int DW = `PERIPH_DATA_W;

    periph_pkg::prio_t   prio_q      [1:NS];
    periph_pkg::prio_t   threshold_q [NT];
    logic [NS:1]         enable_q    [NT];
    logic [NS:1]         pending_q;
    logic [NS:1]         in_service_q;
    periph_pkg::irq_id_t best_id     [NT];
    periph_pkg::prio_t   best_prio   [NT];
    logic [11:0]         off;
    logic [DW-1:0]       rdata_d;
    logic                claim_rd;
    logic                cmpl_wr;
    periph_pkg::irq_id_t claim_id;

    assign off = offset_i[11:0];

    // Strict compare gives ties to the lowest id and skips priority 0
    always_comb begin
        for (int t = 0; t < NT; t++) begin
            best_id[t]   = '0;
            best_prio[t] = threshold_q[t];
            for (int s = 1; s <= NS; s++) begin
                if (pending_q[s] && enable_q[t][s] && prio_q[s] > best_prio[t]) begin
                    best_id[t]   = periph_pkg::irq_id_t'(s);
                    best_prio[t] = prio_q[s];
                end
            end
        end
    end

    // ------------------------------
    // Register read decode
    // ------------------------------
    always_comb begin
        rdata_d  = '0;
        claim_rd = 1'b0;
        cmpl_wr  = 1'b0;
        claim_id = '0;
        for (int s = 1; s <= NS; s++) begin
            if (off == 12'(4 * s)) rdata_d = DW'(prio_q[s]);
        end
        if (off == 12'h080) rdata_d = DW'({pending_q, 1'b0});
        for (int t = 0; t < NT; t++) begin
            if (off == 12'h100 + 12'(4 * t)) rdata_d = DW'({enable_q[t], 1'b0});
            if (off == 12'h200 + 12'(16 * t)) rdata_d = DW'(threshold_q[t]);
            if (off == 12'h204 + 12'(16 * t)) begin
                rdata_d  = DW'(best_id[t]);
                claim_rd = req_i && !write_i;
                cmpl_wr  = req_i && write_i;
                claim_id = best_id[t];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q    <= '0;
            in_service_q <= '0;
            irq_o        <= '0;
            rsp_valid_o  <= 1'b0;
            for (int s = 1; s <= NS; s++) prio_q[s] <= '0;
            for (int t = 0; t < NT; t++) begin
                enable_q[t]    <= '0;
                threshold_q[t] <= '0;
            end
        end else begin
            rsp_valid_o <= req_i;
            if (req_i && write_i) begin
                for (int s = 1; s <= NS; s++) begin
                    if (off == 12'(4 * s)) prio_q[s] <= periph_pkg::prio_t'(wdata_i);
                end
                for (int t = 0; t < NT; t++) begin
                    if (off == 12'h100 + 12'(4 * t)) enable_q[t] <= wdata_i[NS:1];
                    if (off == 12'h200 + 12'(16 * t))
                        threshold_q[t] <= periph_pkg::prio_t'(wdata_i);
                end
            end
            // Gateways
            for (int s = 1; s <= NS; s++) begin
                if (claim_rd && claim_id == periph_pkg::irq_id_t'(s)) begin
                    pending_q[s]    <= 1'b0;
                    in_service_q[s] <= 1'b1;
                end else begin
                    if (irq_src_i[s-1] && !in_service_q[s]) pending_q[s] <= 1'b1;
                    if (cmpl_wr && wdata_i == DW'(s)) in_service_q[s] <= 1'b0;
                end
            end
            for (int t = 0; t < NT; t++) irq_o[t] <= (best_id[t] != '0);
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i && !write_i) rdata_o <= rdata_d;
    end

    a_claim_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        claim_rd |=> rdata_o <= DW'(NS));

endmodule

// ==== periph_decode.sv ====
/*
 * Register request decoder
 * Routes by address window and answers unmapped addresses itself
 */
`timescale 1ns/1ps
`include "periph_settings.svh"

module periph_decode (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_valid_i,
    input  logic                          req_write_i,
    input  logic [`PERIPH_ADDR_W-1:0]     req_addr_i,
    input  logic [`PERIPH_DATA_W-1:0]     req_wdata_i,
    input  logic [`PERIPH_DATA_W/8-1:0]   req_wstrb_i,
    output logic                          plic_req_o,
    output logic                          gpio_req_o,
    output logic                          slv_write_o,
    output logic [`PERIPH_ADDR_W-1:0]     slv_offset_o,
    output logic [`PERIPH_DATA_W-1:0]     slv_wdata_o,
    output logic [`PERIPH_DATA_W/8-1:0]   slv_wstrb_o,
    input  logic                          plic_rsp_valid_i,
    input  logic [`PERIPH_DATA_W-1:0]     plic_rdata_i,
    input  logic                          gpio_rsp_valid_i,
    input  logic [`PERIPH_DATA_W-1:0]     gpio_rdata_i,
    output logic                          rsp_valid_o,
    output logic [`PERIPH_DATA_W-1:0]     rsp_rdata_o,
    output logic                          rsp_err_o
);

    periph_pkg::periph_sel_e sel;
    periph_pkg::periph_sel_e sel_q;   // Held for the response cycle
    logic                    err_q;

    always_comb begin
        if ((req_addr_i & `PLIC_MASK) == `PLIC_BASE) sel = periph_pkg::SEL_PLIC;
        else if ((req_addr_i & `GPIO_MASK) == `GPIO_BASE) sel = periph_pkg::SEL_GPIO;
        else sel = periph_pkg::SEL_NONE;
    end

    assign plic_req_o   = req_valid_i && (sel == periph_pkg::SEL_PLIC);
    assign gpio_req_o   = req_valid_i && (sel == periph_pkg::SEL_GPIO);
    assign slv_write_o  = req_write_i;
    assign slv_offset_o = req_addr_i &
                          ~((sel == periph_pkg::SEL_GPIO) ? `GPIO_MASK : `PLIC_MASK);
    assign slv_wdata_o  = req_wdata_i;
    assign slv_wstrb_o  = req_wstrb_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sel_q <= periph_pkg::SEL_NONE;
            err_q <= 1'b0;
        end else begin
            err_q <= req_valid_i && (sel == periph_pkg::SEL_NONE);
            if (req_valid_i) sel_q <= sel;
        end
    end

    assign rsp_valid_o = plic_rsp_valid_i || gpio_rsp_valid_i || err_q;
    assign rsp_err_o   = err_q;

    always_comb begin
        case (sel_q)
            periph_pkg::SEL_PLIC: rsp_rdata_o = plic_rdata_i;
            periph_pkg::SEL_GPIO: rsp_rdata_o = gpio_rdata_i;
            default:              rsp_rdata_o = `PERIPH_ERR_RDATA;
        endcase
    end

    // At most one answer in any cycle
    a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({plic_rsp_valid_i, gpio_rsp_valid_i, err_q}));

    // Every request gets its answer on the next cycle
    a_rsp_next: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i |=> rsp_valid_o);

endmodule

// ==== axil_to_reg.sv ====
/*
 * AXI4-Lite slave to register request bridge
 * One transaction in flight, writes win a tie against reads
 */
`timescale 1ns/1ps
`include "periph_settings.svh"

module axil_to_reg (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  logic [`PERIPH_ADDR_W-1:0]     awaddr_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    input  logic [`PERIPH_DATA_W-1:0]     wdata_i,
    input  logic [`PERIPH_DATA_W/8-1:0]   wstrb_i,
    output logic                          bvalid_o,
    input  logic                          bready_i,
    output periph_pkg::axi_resp_e         bresp_o,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    input  logic [`PERIPH_ADDR_W-1:0]     araddr_i,
    output logic                          rvalid_o,
    input  logic                          rready_i,
    output logic [`PERIPH_DATA_W-1:0]     rdata_o,
    output periph_pkg::axi_resp_e         rresp_o,
    output logic                          req_valid_o,
    output logic                          req_write_o,
    output logic [`PERIPH_ADDR_W-1:0]     req_addr_o,
    output logic [`PERIPH_DATA_W-1:0]     req_wdata_o,
    output logic [`PERIPH_DATA_W/8-1:0]   req_wstrb_o,
    input  logic                          rsp_valid_i,
    input  logic [`PERIPH_DATA_W-1:0]     rsp_rdata_i,
    input  logic                          rsp_err_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_RESP
    } state_e;

    state_e state_q;
    logic   wr_accept;
    logic   rd_accept;

    // AW and W are taken in the same cycle
    assign awready_o = (state_q == S_IDLE) && awvalid_i && wvalid_i;
    assign wready_o  = awready_o;
    assign arready_o = (state_q == S_IDLE) && !awvalid_i && !wvalid_i;

    assign wr_accept = awvalid_i && awready_o;
    assign rd_accept = arvalid_i && arready_o;

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= S_IDLE;
            req_valid_o <= 1'b0;
            req_write_o <= 1'b0;
            bvalid_o    <= 1'b0;
            rvalid_o    <= 1'b0;
        end else begin
            req_valid_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (wr_accept) begin
                        state_q     <= S_REQ;
                        req_write_o <= 1'b1;
                    end else if (rd_accept) begin
                        state_q     <= S_REQ;
                        req_write_o <= 1'b0;
                    end
                end
                S_REQ: begin
                    req_valid_o <= 1'b1;   // single-cycle pulse
                    state_q     <= S_WAIT;
                end
                S_WAIT: begin
                    if (rsp_valid_i) begin
                        state_q  <= S_RESP;
                        bvalid_o <= req_write_o;
                        rvalid_o <= !req_write_o;
                    end
                end
                S_RESP: begin
                    if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
                        state_q  <= S_IDLE;
                        bvalid_o <= 1'b0;
                        rvalid_o <= 1'b0;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk_i) begin
        if (wr_accept) begin
            req_addr_o  <= awaddr_i;
            req_wdata_o <= wdata_i;
            req_wstrb_o <= wstrb_i;
        end else if (rd_accept) begin
            req_addr_o  <= araddr_i;
            req_wstrb_o <= '0;
        end
        if (state_q == S_WAIT && rsp_valid_i) begin
            if (!req_write_o) begin
                rdata_o <= rsp_rdata_i;
            end
            bresp_o <= rsp_err_i ? periph_pkg::SLVERR : periph_pkg::OKAY;
            rresp_o <= rsp_err_i ? periph_pkg::SLVERR : periph_pkg::OKAY;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o);

endmodule

// ==== periph_pkg.sv ====
/*
 * Peripheral subsystem types
 * Bus response, decoder select and interrupt id/priority
 */
`include "periph_settings.svh"

package periph_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        SEL_PLIC = 2'd0,
        SEL_GPIO = 2'd1,
        SEL_NONE = 2'd2
    } periph_sel_e;

    typedef logic [2:0] irq_id_t;   // 0 means no source

    typedef logic [`PERIPH_PRIO_W-1:0] prio_t;

endpackage

// ==== periph_settings.svh ====
/*
 * Peripheral subsystem settings
 * Bus widths, interrupt counts and the address map
 */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

`define PERIPH_ADDR_W    32
`define PERIPH_DATA_W    32
`define PERIPH_NUM_SRC   4     // 1 is GPIO, 2..4 external
`define PERIPH_NUM_TGT   2
`define PERIPH_PRIO_W    3
`define PERIPH_GPIO_W    8

// Address windows
`define PLIC_BASE        32'h0000_0000
`define PLIC_MASK        32'hFFFF_F000
`define GPIO_BASE        32'h0000_1000
`define GPIO_MASK        32'hFFFF_FF00

`define PERIPH_ERR_RDATA 32'hDEAD_BEEF

`endif
